/* hw/cart_pkg.sv */
// mapper constants; download words are little endian, one header word per even byte address
package cart_pkg;

	// ------------------------------
	// mapper kinds
	// ------------------------------
	localparam int MBC_KIND_W = 3;

	localparam logic [MBC_KIND_W-1:0] MBC_NONE = 3'd0; // 32k linear rom
	localparam logic [MBC_KIND_W-1:0] MBC_1    = 3'd1;
	localparam logic [MBC_KIND_W-1:0] MBC_2    = 3'd2; // 512x4 ram on chip
	localparam logic [MBC_KIND_W-1:0] MBC_3    = 3'd3; // rtc not modelled
	localparam logic [MBC_KIND_W-1:0] MBC_5    = 3'd5;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int CART_ADDR_W = 16; // cpu side
	localparam int ROM_BANK_W  = 9;  // 16k banks, up to 512
	localparam int RAM_BANK_W  = 4;  // 8k banks, up to 16
	localparam int ROM_ADDR_W  = 23; // byte address, 8 MiB
	localparam int CRAM_ADDR_W = 17; // 128 KiB cart ram

	// header word addresses in the download stream
	localparam logic [24:0] HDR_ADDR_CGB  = 25'h142; // cgb flag in high byte
	localparam logic [24:0] HDR_ADDR_TYPE = 25'h146; // sgb flag, cart type
	localparam logic [24:0] HDR_ADDR_SIZE = 25'h148; // rom size, ram size

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA; // low nibble opens the ram

	// ------------------------------
	// cart_addr[15:13] windows
	// ------------------------------
	localparam logic [2:0] WIN_RAM_EN   = 3'b000; // 0000-1FFF
	localparam logic [2:0] WIN_ROM_BANK = 3'b001; // 2000-3FFF
	localparam logic [2:0] WIN_RAM_BANK = 3'b010; // 4000-5FFF
	localparam logic [2:0] WIN_MODE     = 3'b011; // 6000-7FFF
	localparam logic [2:0] WIN_CRAM     = 3'b101; // A000-BFFF

	// one download word, read as either header pair
	// high byte sits at the odd address
	typedef union packed {
		struct packed {
			logic [7:0] mbc_type; // 0x147
			logic [7:0] sgb_flag; // 0x146
		} type_w;
		struct packed {
			logic [7:0] ram_size; // 0x149
			logic [7:0] rom_size; // 0x148
		} size_w;
	} header_word_u;

endpackage

/* hw/cart_header_capture.sv */
// header taken from plain download strobes; only the type and size words are kept, unknown rom size codes fall back to 128 banks
`timescale 1ns/1ps

module cart_header_capture (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            dl_active, // cart download in progress
	input  logic                            dl_wr,
	input  logic [24:0]                     dl_addr,   // byte address
	input  logic [15:0]                     dl_data,
	output logic [cart_pkg::MBC_KIND_W-1:0] mbc_kind,
	output logic [cart_pkg::ROM_BANK_W-1:0] rom_mask,
	output logic [cart_pkg::RAM_BANK_W-1:0] ram_mask
);

	cart_pkg::header_word_u type_word; // 0x146 word
	cart_pkg::header_word_u size_word; // 0x148 word

	logic [7:0] mbc_type;
	logic [7:0] rom_code;
	logic [7:0] ram_code;
	logic [9:0] rom_span; // one bit wider than the mask

	// ------------------------------
	// capture
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_word <= '0; // type 0, no mapper
			size_word <= '0;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == cart_pkg::HDR_ADDR_TYPE) begin
				type_word <= dl_data;
			end
			if (dl_addr == cart_pkg::HDR_ADDR_SIZE) begin
				size_word <= dl_data;
			end
		end
	end

	assign mbc_type = type_word.type_w.mbc_type;
	assign rom_code = size_word.size_w.rom_size;
	assign ram_code = size_word.size_w.ram_size;

	// ------------------------------
	// decode
	// ------------------------------
	always_comb begin
		case (mbc_type) inside
			[8'd1:8'd3]:   mbc_kind = cart_pkg::MBC_1;
			[8'd5:8'd6]:   mbc_kind = cart_pkg::MBC_2;
			[8'd15:8'd19]: mbc_kind = cart_pkg::MBC_3; // with and without timer
			[8'd25:8'd30]: mbc_kind = cart_pkg::MBC_5; // rumble variants too
			default:       mbc_kind = cart_pkg::MBC_NONE; // mmm01, huc etc. unsupported
		endcase
	end

	// code n means 2^(n+1) banks of 16k
	assign rom_span = (10'd2 << rom_code[3:0]) - 10'd1;

	always_comb begin
		if (rom_code <= 8'd8) begin
			rom_mask = rom_span[8:0];
		end else begin
			rom_mask = 9'd127; // 0x52-0x54 odd sizes
		end
	end

	always_comb begin
		if (ram_code == 8'd3) begin
			ram_mask = 4'h3; // 32k, 4 banks
		end else if (ram_code >= 8'd4) begin
			ram_mask = 4'hF; // 128k, 16 banks
		end else begin
			ram_mask = 4'h0; // none, 2k or 8k
		end
	end

endmodule

/* hw/mbc_bank_registers.sv */
// cpu register writes count only with cpu_ce; mbc2 shares the 0x2000 window decode with the others, no address bit 8 split
`timescale 1ns/1ps

module mbc_bank_registers (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             cpu_ce,
	input  logic                             cart_wr,
	input  logic [cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input  logic [7:0]                       cart_di,
	input  logic [cart_pkg::MBC_KIND_W-1:0]  mbc_kind,
	input  logic [cart_pkg::ROM_BANK_W-1:0]  rom_mask,
	input  logic [cart_pkg::RAM_BANK_W-1:0]  ram_mask,
	output logic [cart_pkg::ROM_BANK_W-1:0]  rom_bank,  // effective, masked
	output logic [cart_pkg::RAM_BANK_W-1:0]  ram_bank,  // effective, masked
	output logic                             rtc_mode,
	output logic                             ram_enable
);

	logic [cart_pkg::ROM_BANK_W-1:0] rom_bank_reg;
	logic [cart_pkg::RAM_BANK_W-1:0] ram_bank_reg;
	logic                            mbc1_mode; // 0: 16/8 mode, 1: 4/32 mode
	logic                            rtc_sel;   // mbc3 a000 shows rtc
	logic                            ram_en;

	logic                            reg_wr;
	logic [2:0]                      win;
	logic [6:0]                      bank_field; // bits the mapper really has
	logic [cart_pkg::ROM_BANK_W-1:0] bank_wr_val;

	assign reg_wr = cpu_ce && cart_wr;
	assign win    = cart_addr[15:13];

	// mbc1-3 turn bank 0 into 1
	always_comb begin
		case (mbc_kind)
			cart_pkg::MBC_1: bank_field = {2'b00, cart_di[4:0]};
			cart_pkg::MBC_2: bank_field = {3'b000, cart_di[3:0]};
			default:         bank_field = cart_di[6:0];
		endcase
		bank_wr_val = (bank_field == 7'd0) ? 9'd1 : {2'b00, bank_field};
	end

	// ------------------------------
	// cpu register writes
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_sel      <= 1'b0;
			ram_en       <= 1'b0;
		end else if (reg_wr) begin
			case (win)
				cart_pkg::WIN_RAM_EN: ram_en <= (cart_di[3:0] == cart_pkg::RAM_ENABLE_KEY);
				cart_pkg::WIN_ROM_BANK: begin
					if (mbc_kind == cart_pkg::MBC_5) begin
						if (cart_addr[12]) begin
							rom_bank_reg[8] <= cart_di[0]; // 3000-3fff high bit
						end else begin
							rom_bank_reg[7:0] <= cart_di; // 2000-2fff, 0 is legal here
						end
					end else begin
						rom_bank_reg <= bank_wr_val;
					end
				end
				cart_pkg::WIN_RAM_BANK: begin
					if (mbc_kind == cart_pkg::MBC_3) begin
						rtc_sel <= cart_di[3]; // 08-0c pick an rtc register
						if (!cart_di[3]) begin
							ram_bank_reg <= {2'b00, cart_di[1:0]};
						end
					end else if (mbc_kind == cart_pkg::MBC_5) begin
						ram_bank_reg <= cart_di[3:0];
					end else begin
						ram_bank_reg <= {2'b00, cart_di[1:0]};
					end
				end
				cart_pkg::WIN_MODE: begin
					if (mbc_kind == cart_pkg::MBC_1) begin
						mbc1_mode <= cart_di[0];
					end
				end
				default: ;
			endcase
		end
	end

	// ------------------------------
	// effective banks
	// ------------------------------
	always_comb begin
		case (mbc_kind)
			cart_pkg::MBC_1: begin
				// mode 0: ram bank bits are rom a19-a20, ram fixed at bank 0
				rom_bank = {2'b00, (mbc1_mode ? 2'b00 : ram_bank_reg[1:0]), rom_bank_reg[4:0]}
					& rom_mask;
				ram_bank = (mbc1_mode ? ram_bank_reg : 4'd0) & ram_mask;
			end
			cart_pkg::MBC_2: begin
				rom_bank = rom_bank_reg & rom_mask & 9'h00F; // 16 banks max
				ram_bank = 4'd0; // single 512 nibble block
			end
			cart_pkg::MBC_3: begin
				rom_bank = {2'b00, rom_bank_reg[6:0]} & rom_mask;
				ram_bank = {2'b00, ram_bank_reg[1:0]} & ram_mask;
			end
			default: begin
				rom_bank = rom_bank_reg & rom_mask; // mbc5, none ignores it downstream
				ram_bank = ram_bank_reg & ram_mask;
			end
		endcase
	end

	assign rtc_mode   = rtc_sel && (mbc_kind == cart_pkg::MBC_3);
	assign ram_enable = ram_en;

endmodule

/* hw/mbc_address_map.sv */
// one register stage; cart_rd and cart_wr are plain strobes without cpu_ce, payload holds its last access
`timescale 1ns/1ps

module mbc_address_map (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [cart_pkg::CART_ADDR_W-1:0]  cart_addr,
	input  logic                              cart_rd,
	input  logic                              cart_wr,
	input  logic [7:0]                        cart_di,
	input  logic [cart_pkg::MBC_KIND_W-1:0]   mbc_kind,
	input  logic [cart_pkg::ROM_BANK_W-1:0]   rom_bank,
	input  logic [cart_pkg::RAM_BANK_W-1:0]   ram_bank,
	input  logic                              rtc_mode,
	input  logic                              ram_enable,
	output logic                              rom_rd,
	output logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr,
	output logic                              cram_rd,
	output logic                              cram_wr,
	output logic [cart_pkg::CRAM_ADDR_W-1:0]  cram_addr,
	output logic [7:0]                        cram_wdata,
	output logic                              cram_mode_nibble, // mbc2 4-bit ram
	output logic                              cram_mode_zero,   // mbc3 rtc selected
	output logic                              cram_enabled
);

	logic                             rom_win; // 0000-7fff
	logic                             ram_win; // a000-bfff
	logic [cart_pkg::ROM_BANK_W-1:0]  bank_sel;
	logic [cart_pkg::ROM_ADDR_W-1:0]  rom_addr_d;

	assign rom_win = ~cart_addr[15];
	assign ram_win = (cart_addr[15:13] == cart_pkg::WIN_CRAM);

	// lower 16k always bank 0
	assign bank_sel = cart_addr[14] ? rom_bank : '0;

	always_comb begin
		if (mbc_kind == cart_pkg::MBC_NONE) begin
			rom_addr_d = {{(cart_pkg::ROM_ADDR_W-15){1'b0}}, cart_addr[14:0]}; // 32k linear
		end else begin
			rom_addr_d = {bank_sel, cart_addr[13:0]};
		end
	end

	// ------------------------------
	// strobes
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_rd  <= 1'b0;
			cram_rd <= 1'b0;
			cram_wr <= 1'b0;
		end else begin
			rom_rd  <= cart_rd && rom_win;
			cram_rd <= cart_rd && ram_win; // data two cycles after cart_rd
			cram_wr <= cart_wr && ram_win; // enable checked at the ram
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (cart_rd && rom_win) begin
			rom_addr <= rom_addr_d;
		end
		if ((cart_rd || cart_wr) && ram_win) begin
			cram_addr        <= {ram_bank, cart_addr[12:0]};
			cram_wdata       <= cart_di;
			cram_mode_nibble <= (mbc_kind == cart_pkg::MBC_2);
			cram_mode_zero   <= rtc_mode;
			cram_enabled     <= ram_enable; // read rule and write gate
		end
	end

endmodule

/* hw/cart_ram.sv */
// single-port 128 KiB byte ram, read data one cycle after cram_rd; contents undefined at power up, no backup load
`timescale 1ns/1ps

module cart_ram (
	input  logic                              clk_sys,
	input  logic                              cram_rd,
	input  logic                              cram_wr,
	input  logic [cart_pkg::CRAM_ADDR_W-1:0]  cram_addr,
	input  logic [7:0]                        cram_wdata,
	input  logic                              cram_mode_nibble,
	input  logic                              cram_mode_zero,
	input  logic                              cram_enabled,
	output logic                              cram_valid,
	output logic [7:0]                        cram_data
);

	logic [7:0] mem [2**cart_pkg::CRAM_ADDR_W]; // 16 banks x 8k

	logic [7:0] rd_q;
	logic       rd_enabled;
	logic       rd_nibble;
	logic       rd_zero;

	// ------------------------------
	// ram array
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (cram_wr && cram_enabled) begin
			mem[cram_addr] <= cram_wdata; // full byte, mbc2 masks on read
		end
		if (cram_rd) begin
			rd_q <= mem[cram_addr];
		end
	end

	// rules travel with the read
	always_ff @(posedge clk_sys) begin
		cram_valid <= cram_rd; // cram_rd already cleared by reset upstream
		if (cram_rd) begin
			rd_enabled <= cram_enabled;
			rd_nibble  <= cram_mode_nibble;
			rd_zero    <= cram_mode_zero;
		end
	end

	// ------------------------------
	// read data masking
	// ------------------------------
	always_comb begin
		if (!rd_enabled) begin
			cram_data = 8'hFF; // open bus when ram locked
		end else if (rd_zero) begin
			cram_data = 8'h00; // rtc registers read as 0
		end else if (rd_nibble) begin
			cram_data = {4'hF, rd_q[3:0]}; // upper nibble floats high
		end else begin
			cram_data = rd_q;
		end
	end

endmodule

/* hw/cart_mapper_top.sv */
// cartridge mapper only; rom data comes from outside at rom_addr, outputs are single-cycle pulses with no back-pressure
`timescale 1ns/1ps

module cart_mapper_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	// header download
	input  logic                              dl_active,
	input  logic                              dl_wr,
	input  logic [24:0]                       dl_addr,
	input  logic [15:0]                       dl_data,
	// cpu cartridge bus
	input  logic                              cpu_ce,
	input  logic [cart_pkg::CART_ADDR_W-1:0]  cart_addr,
	input  logic                              cart_rd,
	input  logic                              cart_wr,
	input  logic [7:0]                        cart_di,
	// rom fetch, one cycle after cart_rd
	output logic                              rom_rd,
	output logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr,
	// cart ram read data, two cycles after cart_rd
	output logic                              cram_valid,
	output logic [7:0]                        cram_data
);

	// ------------------------------
	// stage links
	// ------------------------------
	logic [cart_pkg::MBC_KIND_W-1:0]  mbc_kind;
	logic [cart_pkg::ROM_BANK_W-1:0]  rom_mask;
	logic [cart_pkg::RAM_BANK_W-1:0]  ram_mask;

	logic [cart_pkg::ROM_BANK_W-1:0]  rom_bank;
	logic [cart_pkg::RAM_BANK_W-1:0]  ram_bank;
	logic                             rtc_mode;
	logic                             ram_enable;

	logic                             cram_rd;
	logic                             cram_wr;
	logic [cart_pkg::CRAM_ADDR_W-1:0] cram_addr;
	logic [7:0]                       cram_wdata;
	logic                             cram_mode_nibble;
	logic                             cram_mode_zero;
	logic                             cram_enabled;

	cart_header_capture i_cart_header_capture (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.mbc_kind  (mbc_kind),
		.rom_mask  (rom_mask),
		.ram_mask  (ram_mask)
	);

	mbc_bank_registers i_mbc_bank_registers (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cart_wr    (cart_wr),
		.cart_addr  (cart_addr),
		.cart_di    (cart_di),
		.mbc_kind   (mbc_kind),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.rtc_mode   (rtc_mode),
		.ram_enable (ram_enable)
	);

	mbc_address_map i_mbc_address_map (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_addr        (cart_addr),
		.cart_rd          (cart_rd),
		.cart_wr          (cart_wr),
		.cart_di          (cart_di),
		.mbc_kind         (mbc_kind),
		.rom_bank         (rom_bank),
		.ram_bank         (ram_bank),
		.rtc_mode         (rtc_mode),
		.ram_enable       (ram_enable),
		.rom_rd           (rom_rd),
		.rom_addr         (rom_addr),
		.cram_rd          (cram_rd),
		.cram_wr          (cram_wr),
		.cram_addr        (cram_addr),
		.cram_wdata       (cram_wdata),
		.cram_mode_nibble (cram_mode_nibble),
		.cram_mode_zero   (cram_mode_zero),
		.cram_enabled     (cram_enabled)
	);

	cart_ram i_cart_ram (
		.clk_sys          (clk_sys),
		.cram_rd          (cram_rd),
		.cram_wr          (cram_wr),
		.cram_addr        (cram_addr),
		.cram_wdata       (cram_wdata),
		.cram_mode_nibble (cram_mode_nibble),
		.cram_mode_zero   (cram_mode_zero),
		.cram_enabled     (cram_enabled),
		.cram_valid       (cram_valid),
		.cram_data        (cram_data)
	);

endmodule

/* verification/cart_mapper_assertions.sv */
// bound into cart_mapper_top; checks the output strobes against the cpu reads that caused them
`timescale 1ns/1ps

module cart_mapper_assertions (
	input logic                             clk_sys,
	input logic                             reset,
	input logic [cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input logic                             cart_rd,
	input logic                             rom_rd,
	input logic                             cram_valid
);

	// ------------------------------
	// output strobes
	// ------------------------------
	no_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_rd && cram_valid))
		else $error("rom_rd and cram_valid high in the same cycle");

	// one rom pulse per rom window read, one cycle later
	rom_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rd |-> ($past(cart_rd) && !$past(cart_addr[15])))
		else $error("rom_rd without a rom window read one cycle before");

	// ram data two cycles after a read in a000-bfff
	cram_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cram_valid |-> ($past(cart_rd, 2) && ($past(cart_addr[15:13], 2) == cart_pkg::WIN_CRAM)))
		else $error("cram_valid without a ram window read two cycles before");

	after_reset: assert property (@(posedge clk_sys)
		($past(reset) && !reset) |-> (!rom_rd && !cram_valid))
		else $error("output strobe high in the first cycle after reset");

endmodule

bind cart_mapper_top cart_mapper_assertions i_cart_mapper_assertions (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cart_addr  (cart_addr),
	.cart_rd    (cart_rd),
	.rom_rd     (rom_rd),
	.cram_valid (cram_valid)
);

/* verification/cart_mapper_tb.sv */
// one table row per clock, back to back; a ram read row must not sit directly before a rom read row
`timescale 1ns/1ps

module cart_mapper_tb;

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_HDR,      // download word, dl_active high
		OP_HDR_OFF,  // download word, dl_active low
		OP_REG,      // cpu write with cpu_ce
		OP_REG_NOCE, // cpu write, no cpu_ce
		OP_ROM_RD,
		OP_RAM_WR,
		OP_RAM_RD
	} op_e;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic        cpu_ce;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic        rom_rd;
	logic [22:0] rom_addr;
	logic        cram_valid;
	logic [7:0]  cram_data;

	// stimulus table, one entry per cycle
	op_e         row_op[$];
	logic [24:0] row_addr[$];
	logic [15:0] row_data[$];
	logic [22:0] row_exp[$];
	string       row_name[$];
	logic        table_ready;
	int          fail_count;

	// pulses still in flight
	logic        rom_pend;   // due next cycle
	logic [22:0] rom_exp;
	string       rom_name;
	logic        cram_pend1; // due in two cycles
	logic [7:0]  cram_exp1;
	string       cram_name1;
	logic        cram_pend2; // due next cycle
	logic [7:0]  cram_exp2;
	string       cram_name2;

	cart_mapper_top i_cart_mapper_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.cpu_ce     (cpu_ce),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_di    (cart_di),
		.rom_rd     (rom_rd),
		.rom_addr   (rom_addr),
		.cram_valid (cram_valid),
		.cram_data  (cram_data)
	);

	always #5 clk_sys = ~clk_sys; // 100 MHz

	// ------------------------------
	// table helpers
	// ------------------------------
	task automatic add_row(input op_e op, input int unsigned addr, input int unsigned data,
			input int unsigned exp, input string name);
		row_op.push_back(op);
		row_addr.push_back(addr[24:0]);
		row_data.push_back(data[15:0]);
		row_exp.push_back(exp[22:0]); // rom byte address or ram read byte
		row_name.push_back(name);
	endtask

	task automatic drive_row(input int i);
		logic [24:0] a;
		logic [15:0] d;
		a = row_addr[i];
		d = row_data[i];
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		cpu_ce    = 1'b0;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		dl_addr   = a;
		dl_data   = d;
		cart_addr = a[15:0];
		cart_di   = d[7:0];
		case (row_op[i])
			OP_HDR: begin
				dl_active = 1'b1;
				dl_wr     = 1'b1;
			end
			OP_HDR_OFF: dl_wr = 1'b1; // must be dropped
			OP_REG, OP_RAM_WR: begin
				cpu_ce  = 1'b1;
				cart_wr = 1'b1;
			end
			OP_REG_NOCE: cart_wr = 1'b1;
			OP_ROM_RD, OP_RAM_RD: begin
				cpu_ce  = 1'b1;
				cart_rd = 1'b1;
			end
			default: ;
		endcase
	endtask

	// shift the expected pulses along with the row just driven
	task automatic track_row(input int i);
		logic [22:0] e;
		e          = row_exp[i];
		cram_pend2 = cram_pend1;
		cram_exp2  = cram_exp1;
		cram_name2 = cram_name1;
		cram_pend1 = (row_op[i] == OP_RAM_RD);
		cram_exp1  = e[7:0];
		cram_name1 = row_name[i];
		rom_pend   = (row_op[i] == OP_ROM_RD);
		rom_exp    = e;
		rom_name   = row_name[i];
	endtask

	task automatic check_value(input string name, input string what,
			input int unsigned exp, input int unsigned act);
		assert (act == exp) else begin
			fail_count++;
			$display("Error: %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
			$display("test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// strobes checked every cycle, so extra or stretched pulses fail too
	task automatic check_outputs();
		check_value(rom_name, "rom_rd", 32'(rom_pend), 32'(rom_rd));
		if (rom_pend) begin
			check_value(rom_name, "rom_addr", 32'(rom_exp), 32'(rom_addr));
		end
		check_value(cram_name2, "cram_valid", 32'(cram_pend2), 32'(cram_valid));
		if (cram_pend2) begin
			check_value(cram_name2, "cram_data", 32'(cram_exp2), 32'(cram_data));
		end
	endtask

	// ------------------------------
	// stimulus table
	// ------------------------------
	task automatic build_table();
		// mbc1, 32 banks then 128
		add_row(OP_HDR,      'h146,  'h0100, 0,         "mbc1_header");     // type 01
		add_row(OP_HDR,      'h148,  'h0004, 0,         "mbc1_header");     // rom code 4
		add_row(OP_REG,      'h2000, 'h00,   0,         "mbc1_bank0_is_1");
		add_row(OP_ROM_RD,   'h4000, 0,      'h004000,  "mbc1_bank0_is_1");
		add_row(OP_ROM_RD,   'h0123, 0,      'h000123,  "mbc1_low_window"); // fixed bank 0
		add_row(OP_REG,      'h2000, 'h25,   0,         "mbc1_mirror");
		add_row(OP_REG,      'h4000, 'h02,   0,         "mbc1_mirror");     // a19-a20 set
		add_row(OP_ROM_RD,   'h4ABC, 0,      'h014ABC,  "mbc1_mirror");     // bank 0x05
		add_row(OP_HDR,      'h148,  'h0006, 0,         "mbc1_ram_bits");   // mask 0x7f
		add_row(OP_ROM_RD,   'h4001, 0,      'h114001,  "mbc1_ram_bits");   // bank 0x45
		add_row(OP_REG,      'h6000, 'h01,   0,         "mbc1_mode1");
		add_row(OP_ROM_RD,   'h7FFF, 0,      'h017FFF,  "mbc1_mode1");      // back to 0x05
		// mbc5, 512 banks, 4 ram banks
		add_row(OP_HDR,      'h146,  'h1900, 0,         "mbc5_header");
		add_row(OP_HDR,      'h148,  'h0308, 0,         "mbc5_header");
		add_row(OP_REG,      'h2000, 'hA3,   0,         "mbc5_bank_9bit");
		add_row(OP_REG,      'h3000, 'h01,   0,         "mbc5_bank_9bit");
		add_row(OP_ROM_RD,   'h4010, 0,      'h68C010,  "mbc5_bank_9bit");  // bank 0x1a3
		add_row(OP_REG_NOCE, 'h2000, 'h11,   0,         "mbc5_no_cpu_ce");
		add_row(OP_ROM_RD,   'h4010, 0,      'h68C010,  "mbc5_no_cpu_ce");
		add_row(OP_REG,      'h3000, 'h00,   0,         "mbc5_bank0_legal");
		add_row(OP_REG,      'h2000, 'h00,   0,         "mbc5_bank0_legal");
		add_row(OP_ROM_RD,   'h4000, 0,      'h000000,  "mbc5_bank0_legal");
		// ram enable and banking, still mbc5
		add_row(OP_RAM_RD,   'hA010, 0,      'hFF,      "ram_locked");
		add_row(OP_REG,      'h0000, 'h0A,   0,         "ram_bank0");
		add_row(OP_REG,      'h4000, 'h00,   0,         "ram_bank0");
		add_row(OP_RAM_WR,   'hA010, 'h5C,   0,         "ram_bank0");
		add_row(OP_RAM_RD,   'hA010, 0,      'h5C,      "ram_bank0");
		add_row(OP_REG,      'h4000, 'h02,   0,         "ram_bank2");
		add_row(OP_RAM_WR,   'hA010, 'hC3,   0,         "ram_bank2");
		add_row(OP_RAM_RD,   'hA010, 0,      'hC3,      "ram_bank2");
		add_row(OP_REG,      'h4000, 'h00,   0,         "ram_bank0_kept");
		add_row(OP_RAM_RD,   'hA010, 0,      'h5C,      "ram_bank0_kept");
		add_row(OP_REG,      'h0000, 'h00,   0,         "ram_relocked");
		add_row(OP_RAM_RD,   'hA010, 0,      'hFF,      "ram_relocked");
		// mbc2, 4 bit bank and nibble ram
		add_row(OP_HDR,      'h146,  'h0500, 0,         "mbc2_header");
		add_row(OP_REG,      'h2000, 'h1F,   0,         "mbc2_rom_bank");
		add_row(OP_ROM_RD,   'h4000, 0,      'h03C000,  "mbc2_rom_bank");   // bank 15
		add_row(OP_REG,      'h0000, 'h0A,   0,         "mbc2_nibble");
		add_row(OP_RAM_WR,   'hA020, 'h37,   0,         "mbc2_nibble");
		add_row(OP_RAM_RD,   'hA020, 0,      'hF7,      "mbc2_nibble");
		// mbc3, ram still enabled
		add_row(OP_HDR,      'h146,  'h1300, 0,         "mbc3_header");
		add_row(OP_REG,      'h2000, 'h00,   0,         "mbc3_bank0_is_1");
		add_row(OP_ROM_RD,   'h4000, 0,      'h004000,  "mbc3_bank0_is_1");
		add_row(OP_REG,      'h4000, 'h01,   0,         "mbc3_ram");
		add_row(OP_RAM_WR,   'hA030, 'h9E,   0,         "mbc3_ram");
		add_row(OP_RAM_RD,   'hA030, 0,      'h9E,      "mbc3_ram");
		add_row(OP_REG,      'h4000, 'h08,   0,         "mbc3_rtc");
		add_row(OP_RAM_RD,   'hA030, 0,      'h00,      "mbc3_rtc");
		add_row(OP_REG,      'h4000, 'h01,   0,         "mbc3_rtc_off");
		add_row(OP_RAM_RD,   'hA030, 0,      'h9E,      "mbc3_rtc_off");
		// no mapper
		add_row(OP_HDR,      'h146,  'h0000, 0,         "none_linear");
		add_row(OP_ROM_RD,   'h5123, 0,      'h005123,  "none_linear");
		add_row(OP_REG,      'h2000, 'h07,   0,         "none_bank_ignored");
		add_row(OP_ROM_RD,   'h5123, 0,      'h005123,  "none_bank_ignored");
		add_row(OP_HDR_OFF,  'h146,  'h0100, 0,         "dl_inactive");     // stays none
		add_row(OP_ROM_RD,   'h5123, 0,      'h005123,  "dl_inactive");
		add_row(OP_IDLE,     0,      0,      0,         "drain");           // last cram pulse
		add_row(OP_IDLE,     0,      0,      0,         "drain");
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = row_op.size() * 10 + 50; // one row per cycle, wide margin plus reset
		repeat (limit) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the table did not finish", limit);
		$display("test failed");
		$fatal(1, "timeout");
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : stimulus
		clk_sys     = 1'b0;
		reset       = 1'b1;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		cpu_ce      = 1'b0;
		cart_addr   = '0;
		cart_rd     = 1'b0;
		cart_wr     = 1'b0;
		cart_di     = '0;
		table_ready = 1'b0;
		fail_count  = 0;
		rom_pend    = 1'b0;
		rom_exp     = '0;
		rom_name    = "reset";
		cram_pend1  = 1'b0;
		cram_exp1   = '0;
		cram_name1  = "reset";
		cram_pend2  = 1'b0;
		cram_exp2   = '0;
		cram_name2  = "reset";
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk_sys); // two reset cycles
		@(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < row_op.size(); i++) begin
			@(negedge clk_sys);
			check_outputs(); // results of earlier rows
			drive_row(i);
			track_row(i);
		end
		if (fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* files.f */
hw/cart_pkg.sv
hw/cart_header_capture.sv
hw/mbc_bank_registers.sv
hw/mbc_address_map.sv
hw/cart_ram.sv
hw/cart_mapper_top.sv
verification/cart_mapper_assertions.sv
verification/cart_mapper_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cartridge mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module cart_mapper_tb \
	-f files.f \
	-o cart_mapper_sim

# the log decides, so a fatal exit must not end the script here
./obj_dir/cart_mapper_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
